//--- rtl/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // widths, fixed for the whole bridge
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int AXI_DATA_W = 64;
  localparam int STRB_W     = 4;
  localparam int AXI_STRB_W = 8;
  localparam int AXI_ID_W   = 4;

  // machine timer words, answered locally
  localparam logic [ADDR_W-1:0] RTC_ADDR    = 32'ha000_0048;
  localparam logic [ADDR_W-1:0] RTC_ADDR_UP = RTC_ADDR + 32'd4;

  // requester currently owning the bus
  typedef enum logic [1:0] {
    SRC_NONE = 2'd0,
    SRC_IFU  = 2'd1,
    SRC_LSU  = 2'd2
  } bus_src_e;

  // single-beat AXI master states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_ADDR = 2'd1,
    ST_RESP = 2'd2,
    ST_DONE = 2'd3
  } axi_state_e;

  // request of the granted port, byte strobes still at bit 0
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
    logic              write;
  } bus_req_t;

  // one beat already steered onto the 64-bit lanes
  typedef struct packed {
    logic [ADDR_W-1:0]     addr;
    logic [2:0]            size;
    logic [AXI_DATA_W-1:0] wdata;
    logic [AXI_STRB_W-1:0] wstrb;
    logic                  write;
  } axi_beat_t;

  // done pulse plus 32-bit read word
  typedef struct packed {
    logic              done;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

//--- rtl/bus_req_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module bus_req_arbiter (
  input  wire                        clk,
  input  wire                        arst_n_i,
  // fetch port
  input  wire                        ifu_arvalid_i,
  input  wire [bus_pkg::ADDR_W-1:0]  ifu_araddr_i,
  // load port
  input  wire                        lsu_arvalid_i,
  input  wire [bus_pkg::ADDR_W-1:0]  lsu_araddr_i,
  input  wire [bus_pkg::STRB_W-1:0]  lsu_rstrb_i,
  // store port
  input  wire                        lsu_awvalid_i,
  input  wire [bus_pkg::ADDR_W-1:0]  lsu_awaddr_i,
  input  wire [bus_pkg::DATA_W-1:0]  lsu_wdata_i,
  input  wire [bus_pkg::STRB_W-1:0]  lsu_wstrb_i,
  // towards steer
  output bus_pkg::bus_req_t          req_o,
  output logic                       issue_o,
  input  wire bus_pkg::bus_rsp_t     rsp_i,
  // back to the requesters
  output logic                       ifu_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0] ifu_rdata_o,
  output logic                       lsu_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0] lsu_rdata_o,
  output logic                       lsu_wready_o
);
  import bus_pkg::*;

  bus_src_e grant_q;
  logic     busy_q;
  logic     issue_q;
  bus_req_t req_q;
  logic     lsu_req;
  logic     any_req;
  logic     take;

  assign lsu_req = lsu_arvalid_i | lsu_awvalid_i;
  assign any_req = lsu_req | ifu_arvalid_i;
  // grant only while idle, never on the edge that ends a transfer
  assign take = !busy_q && any_req;

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      grant_q <= SRC_NONE;
      busy_q  <= 1'b0;
      issue_q <= 1'b0;
    end
    else
    begin
      issue_q <= take;
      if (take)
      begin
        // load/store wins a tie with fetch
        grant_q <= lsu_req ? SRC_LSU : SRC_IFU;
        busy_q  <= 1'b1;
      end
      else if (busy_q && rsp_i.done)
      begin
        grant_q <= SRC_NONE;
        busy_q  <= 1'b0;
      end
    end
  end

  // request fields captured at grant
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      if (lsu_awvalid_i)
        req_q <= '{addr: lsu_awaddr_i, wdata: lsu_wdata_i, strb: lsu_wstrb_i, write: 1'b1};
      else if (lsu_arvalid_i)
        req_q <= '{addr: lsu_araddr_i, wdata: '0, strb: lsu_rstrb_i, write: 1'b0};
      else
        req_q <= '{addr: ifu_araddr_i, wdata: '0, strb: '1, write: 1'b0};
    end
  end

  assign req_o   = req_q;
  assign issue_o = issue_q;

  // route done and data to the owner only
  assign ifu_rvalid_o = rsp_i.done && (grant_q == SRC_IFU);
  assign ifu_rdata_o  = (grant_q == SRC_IFU) ? rsp_i.rdata : '0;
  assign lsu_rvalid_o = rsp_i.done && (grant_q == SRC_LSU) && !req_q.write;
  assign lsu_rdata_o  = (grant_q == SRC_LSU && !req_q.write) ? rsp_i.rdata : '0;
  assign lsu_wready_o = rsp_i.done && (grant_q == SRC_LSU) && req_q.write;

endmodule

`default_nettype wire

//--- rtl/bus_lane_steer.sv
`timescale 1ns/100ps
`default_nettype none

module bus_lane_steer (
  input  wire                        clk,
  input  wire                        arst_n_i,
  // request from the arbiter
  input  wire bus_pkg::bus_req_t     req_i,
  input  wire                        issue_i,
  // AXI side
  output bus_pkg::axi_beat_t         beat_o,
  output logic                       start_o,
  // timer side
  output logic                       timer_rd_o,
  output logic                       timer_hi_o,
  // responses
  input  wire bus_pkg::bus_rsp_t     axi_rsp_i,
  input  wire bus_pkg::bus_rsp_t     timer_rsp_i,
  output bus_pkg::bus_rsp_t          rsp_o
);
  import bus_pkg::*;

  logic                  is_timer;
  logic [1:0]            off;
  logic [2:0]            size;
  logic [DATA_W-1:0]     wword;
  logic [STRB_W-1:0]     strb_sh;
  logic [AXI_STRB_W-1:0] wstrb;
  logic                  tgt_timer_q;
  logic [1:0]            off_q;
  bus_rsp_t              sel_rsp;

  // timer window is read only
  assign is_timer = !req_i.write &&
                    (req_i.addr == RTC_ADDR || req_i.addr == RTC_ADDR_UP);
  assign off = req_i.addr[1:0];

  // strobe pattern to AXI size
  always_comb
  begin
    case (req_i.strb)
      4'b0001: size = 3'd0;
      4'b0011: size = 3'd1;
      default: size = 3'd2;
    endcase
  end

  // byte offset moves data and strobes up
  assign wword   = req_i.wdata << {off, 3'b000};
  assign strb_sh = req_i.strb << off;
  // word lane picked by address bit 2
  assign wstrb = req_i.addr[2] ? {strb_sh, {STRB_W{1'b0}}} : {{STRB_W{1'b0}}, strb_sh};

  assign beat_o = '{
    addr:  req_i.addr,
    size:  size,
    // same word on both halves, the strobes pick one
    wdata: {wword, wword},
    wstrb: wstrb,
    write: req_i.write
  };

  assign start_o    = issue_i && !is_timer;
  assign timer_rd_o = issue_i && is_timer;
  assign timer_hi_o = (req_i.addr == RTC_ADDR_UP);

  // remember who answers the pending request
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      tgt_timer_q <= 1'b0;
    else if (issue_i)
      tgt_timer_q <= is_timer;
  end

  // byte offset for the return shift
  always_ff @(posedge clk)
  begin
    if (issue_i)
      off_q <= off;
  end

  assign sel_rsp = tgt_timer_q ? timer_rsp_i : axi_rsp_i;

  // master already returns the addressed 32-bit lane
  // shift the wanted bytes down to bit 0, zeros on top
  assign rsp_o = '{
    done:  sel_rsp.done,
    rdata: sel_rsp.rdata >> {off_q, 3'b000}
  };

endmodule

`default_nettype wire

//--- rtl/bus_axi_master.sv
`timescale 1ns/100ps
`default_nettype none

module bus_axi_master (
  input  wire                            clk,
  input  wire                            arst_n_i,
  input  wire bus_pkg::axi_beat_t        beat_i,
  input  wire                            start_i,
  output bus_pkg::bus_rsp_t              rsp_o,
  // write address
  output logic [bus_pkg::AXI_ID_W-1:0]   m_axi_awid,
  output logic [bus_pkg::ADDR_W-1:0]     m_axi_awaddr,
  output logic [7:0]                     m_axi_awlen,
  output logic [2:0]                     m_axi_awsize,
  output logic [1:0]                     m_axi_awburst,
  output logic                           m_axi_awvalid,
  input  wire                            m_axi_awready,
  // write data
  output logic [bus_pkg::AXI_DATA_W-1:0] m_axi_wdata,
  output logic [bus_pkg::AXI_STRB_W-1:0] m_axi_wstrb,
  output logic                           m_axi_wlast,
  output logic                           m_axi_wvalid,
  input  wire                            m_axi_wready,
  // write response
  input  wire [bus_pkg::AXI_ID_W-1:0]    m_axi_bid,
  input  wire [1:0]                      m_axi_bresp,
  input  wire                            m_axi_bvalid,
  output logic                           m_axi_bready,
  // read address
  output logic [bus_pkg::AXI_ID_W-1:0]   m_axi_arid,
  output logic [bus_pkg::ADDR_W-1:0]     m_axi_araddr,
  output logic [7:0]                     m_axi_arlen,
  output logic [2:0]                     m_axi_arsize,
  output logic [1:0]                     m_axi_arburst,
  output logic                           m_axi_arvalid,
  input  wire                            m_axi_arready,
  // read data
  input  wire [bus_pkg::AXI_ID_W-1:0]    m_axi_rid,
  input  wire [bus_pkg::AXI_DATA_W-1:0]  m_axi_rdata,
  input  wire [1:0]                      m_axi_rresp,
  input  wire                            m_axi_rlast,
  input  wire                            m_axi_rvalid,
  output logic                           m_axi_rready
);
  import bus_pkg::*;

  axi_state_e        state_q;
  axi_beat_t         beat_q;
  logic              aw_done_q;
  logic              w_done_q;
  logic [DATA_W-1:0] rdata_q;
  logic              aw_ok;
  logic              w_ok;

  // handshake seen now or earlier
  assign aw_ok = aw_done_q || (m_axi_awvalid && m_axi_awready);
  assign w_ok  = w_done_q || (m_axi_wvalid && m_axi_wready);

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q   <= ST_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          aw_done_q <= 1'b0;
          w_done_q  <= 1'b0;
          if (start_i)
            state_q <= ST_ADDR;
        end
        ST_ADDR:
        begin
          if (beat_q.write)
          begin
            // aw and w may finish in either order
            aw_done_q <= aw_ok;
            w_done_q  <= w_ok;
            if (aw_ok && w_ok)
              state_q <= ST_RESP;
          end
          else if (m_axi_arready)
            state_q <= ST_RESP;
        end
        ST_RESP:
        begin
          if (beat_q.write ? m_axi_bvalid : m_axi_rvalid)
            state_q <= ST_DONE;
        end
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

  // beat payload and read word
  always_ff @(posedge clk)
  begin
    if (state_q == ST_IDLE && start_i)
      beat_q <= beat_i;
    if (state_q == ST_RESP && !beat_q.write && m_axi_rvalid)
      rdata_q <= beat_q.addr[2] ? m_axi_rdata[63:32] : m_axi_rdata[31:0];
    else if (state_q == ST_RESP && beat_q.write && m_axi_bvalid)
      rdata_q <= '0;
  end

  assign rsp_o = '{done: (state_q == ST_DONE), rdata: rdata_q};

  // single beat, id zero, incr
  assign m_axi_awid    = '0;
  assign m_axi_awaddr  = beat_q.addr;
  assign m_axi_awlen   = 8'd0;
  assign m_axi_awsize  = beat_q.size;
  assign m_axi_awburst = 2'b01;
  assign m_axi_awvalid = (state_q == ST_ADDR) && beat_q.write && !aw_done_q;
  assign m_axi_wdata   = beat_q.wdata;
  assign m_axi_wstrb   = beat_q.wstrb;
  assign m_axi_wlast   = 1'b1;
  assign m_axi_wvalid  = (state_q == ST_ADDR) && beat_q.write && !w_done_q;
  assign m_axi_bready  = (state_q == ST_RESP) && beat_q.write;
  assign m_axi_arid    = '0;
  assign m_axi_araddr  = beat_q.addr;
  assign m_axi_arlen   = 8'd0;
  assign m_axi_arsize  = beat_q.size;
  assign m_axi_arburst = 2'b01;
  assign m_axi_arvalid = (state_q == ST_ADDR) && !beat_q.write;
  assign m_axi_rready  = (state_q == ST_RESP) && !beat_q.write;

endmodule

`default_nettype wire

//--- rtl/bus_clint_timer.sv
`timescale 1ns/100ps
`default_nettype none

module bus_clint_timer (
  input  wire                clk,
  input  wire                arst_n_i,
  input  wire                rd_i,
  input  wire                hi_i,
  output bus_pkg::bus_rsp_t  rsp_o
);
  import bus_pkg::*;

  logic [63:0]       mtime_q;
  logic              done_q;
  logic [DATA_W-1:0] rdata_q;

  // free-running mtime and read done
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      mtime_q <= 64'd0;
      done_q  <= 1'b0;
    end
    else
    begin
      mtime_q <= mtime_q + 64'd1;
      done_q  <= rd_i;
    end
  end

  // word picked at the read strobe
  always_ff @(posedge clk)
  begin
    if (rd_i)
      rdata_q <= hi_i ? mtime_q[63:32] : mtime_q[31:0];
  end

  assign rsp_o = '{done: done_q, rdata: rdata_q};

endmodule

`default_nettype wire

//--- rtl/bus_bridge_top.sv
`timescale 1ns/100ps
`default_nettype none

module bus_bridge_top (
  input  wire                            clk,
  input  wire                            arst_n_i,
  // fetch
  input  wire                            ifu_arvalid_i,
  input  wire [bus_pkg::ADDR_W-1:0]      ifu_araddr_i,
  output logic                           ifu_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0]     ifu_rdata_o,
  // load
  input  wire                            lsu_arvalid_i,
  input  wire [bus_pkg::ADDR_W-1:0]      lsu_araddr_i,
  input  wire [bus_pkg::STRB_W-1:0]      lsu_rstrb_i,
  output logic                           lsu_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0]     lsu_rdata_o,
  // store
  input  wire                            lsu_awvalid_i,
  input  wire [bus_pkg::ADDR_W-1:0]      lsu_awaddr_i,
  input  wire [bus_pkg::DATA_W-1:0]      lsu_wdata_i,
  input  wire [bus_pkg::STRB_W-1:0]      lsu_wstrb_i,
  output logic                           lsu_wready_o,
  // AXI4 master
  output logic [bus_pkg::AXI_ID_W-1:0]   m_axi_awid,
  output logic [bus_pkg::ADDR_W-1:0]     m_axi_awaddr,
  output logic [7:0]                     m_axi_awlen,
  output logic [2:0]                     m_axi_awsize,
  output logic [1:0]                     m_axi_awburst,
  output logic                           m_axi_awvalid,
  input  wire                            m_axi_awready,
  output logic [bus_pkg::AXI_DATA_W-1:0] m_axi_wdata,
  output logic [bus_pkg::AXI_STRB_W-1:0] m_axi_wstrb,
  output logic                           m_axi_wlast,
  output logic                           m_axi_wvalid,
  input  wire                            m_axi_wready,
  input  wire [bus_pkg::AXI_ID_W-1:0]    m_axi_bid,
  input  wire [1:0]                      m_axi_bresp,
  input  wire                            m_axi_bvalid,
  output logic                           m_axi_bready,
  output logic [bus_pkg::AXI_ID_W-1:0]   m_axi_arid,
  output logic [bus_pkg::ADDR_W-1:0]     m_axi_araddr,
  output logic [7:0]                     m_axi_arlen,
  output logic [2:0]                     m_axi_arsize,
  output logic [1:0]                     m_axi_arburst,
  output logic                           m_axi_arvalid,
  input  wire                            m_axi_arready,
  input  wire [bus_pkg::AXI_ID_W-1:0]    m_axi_rid,
  input  wire [bus_pkg::AXI_DATA_W-1:0]  m_axi_rdata,
  input  wire [1:0]                      m_axi_rresp,
  input  wire                            m_axi_rlast,
  input  wire                            m_axi_rvalid,
  output logic                           m_axi_rready
);
  import bus_pkg::*;

  bus_req_t  req;
  logic      issue;
  axi_beat_t beat;
  logic      start;
  logic      timer_rd;
  logic      timer_hi;
  bus_rsp_t  axi_rsp;
  bus_rsp_t  timer_rsp;
  bus_rsp_t  rsp;

  // one requester at a time
  bus_req_arbiter u_arbiter (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_araddr_i  (ifu_araddr_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_rstrb_i   (lsu_rstrb_i),
    .lsu_awvalid_i (lsu_awvalid_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .req_o         (req),
    .issue_o       (issue),
    .rsp_i         (rsp),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .ifu_rdata_o   (ifu_rdata_o),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_rdata_o   (lsu_rdata_o),
    .lsu_wready_o  (lsu_wready_o)
  );

  // target decode and lane steering
  bus_lane_steer u_steer (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_i       (req),
    .issue_i     (issue),
    .beat_o      (beat),
    .start_o     (start),
    .timer_rd_o  (timer_rd),
    .timer_hi_o  (timer_hi),
    .axi_rsp_i   (axi_rsp),
    .timer_rsp_i (timer_rsp),
    .rsp_o       (rsp)
  );

  bus_axi_master u_axi (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .beat_i        (beat),
    .start_i       (start),
    .rsp_o         (axi_rsp),
    .m_axi_awid    (m_axi_awid),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_awlen   (m_axi_awlen),
    .m_axi_awsize  (m_axi_awsize),
    .m_axi_awburst (m_axi_awburst),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wstrb   (m_axi_wstrb),
    .m_axi_wlast   (m_axi_wlast),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_bid     (m_axi_bid),
    .m_axi_bresp   (m_axi_bresp),
    .m_axi_bvalid  (m_axi_bvalid),
    .m_axi_bready  (m_axi_bready),
    .m_axi_arid    (m_axi_arid),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arlen   (m_axi_arlen),
    .m_axi_arsize  (m_axi_arsize),
    .m_axi_arburst (m_axi_arburst),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_rid     (m_axi_rid),
    .m_axi_rdata   (m_axi_rdata),
    .m_axi_rresp   (m_axi_rresp),
    .m_axi_rlast   (m_axi_rlast),
    .m_axi_rvalid  (m_axi_rvalid),
    .m_axi_rready  (m_axi_rready)
  );

  // local mtime, never on AXI
  bus_clint_timer u_timer (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .rd_i     (timer_rd),
    .hi_i     (timer_hi),
    .rsp_o    (timer_rsp)
  );

endmodule

`default_nettype wire

//--- verification/bus_bridge_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module bus_bridge_assertions (
  input wire                            clk,
  input wire                            arst_n_i,
  input wire                            start_i,
  input wire                            done_i,
  input wire                            m_axi_arvalid,
  input wire                            m_axi_arready,
  input wire [bus_pkg::ADDR_W-1:0]      m_axi_araddr,
  input wire                            m_axi_awvalid,
  input wire                            m_axi_awready,
  input wire [bus_pkg::ADDR_W-1:0]      m_axi_awaddr,
  input wire                            m_axi_wvalid,
  input wire                            m_axi_wready,
  input wire [bus_pkg::AXI_DATA_W-1:0]  m_axi_wdata,
  input wire [bus_pkg::AXI_STRB_W-1:0]  m_axi_wstrb
);
  logic pending_q;

  // open transfer between start and done
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      pending_q <= 1'b0;
    else if (start_i)
      pending_q <= 1'b1;
    else if (done_i)
      pending_q <= 1'b0;
  end

  // valid stays up with a frozen payload until ready
  ar_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_araddr))
    else $error("arvalid dropped or araddr changed before arready");
  aw_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr))
    else $error("awvalid dropped or awaddr changed before awready");
  w_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    m_axi_wvalid && !m_axi_wready |=>
      m_axi_wvalid && $stable(m_axi_wdata) && $stable(m_axi_wstrb))
    else $error("wvalid dropped or write payload changed before wready");

  // one done per start, single cycle
  done_once: assert property (@(posedge clk) disable iff (!arst_n_i)
    done_i |-> pending_q ##1 !done_i)
    else $error("done without a start or longer than one cycle");

  // quiet bus while in reset
  rst_quiet: assert property (@(posedge clk)
    !arst_n_i |-> !m_axi_arvalid && !m_axi_awvalid && !m_axi_wvalid)
    else $error("AXI valid high during reset");

endmodule

bind bus_axi_master bus_bridge_assertions u_assertions (
  .clk           (clk),
  .arst_n_i      (arst_n_i),
  .start_i       (start_i),
  .done_i        (rsp_o.done),
  .m_axi_arvalid (m_axi_arvalid),
  .m_axi_arready (m_axi_arready),
  .m_axi_araddr  (m_axi_araddr),
  .m_axi_awvalid (m_axi_awvalid),
  .m_axi_awready (m_axi_awready),
  .m_axi_awaddr  (m_axi_awaddr),
  .m_axi_wvalid  (m_axi_wvalid),
  .m_axi_wready  (m_axi_wready),
  .m_axi_wdata   (m_axi_wdata),
  .m_axi_wstrb   (m_axi_wstrb)
);

`default_nettype wire

//--- verification/bus_bridge_tb.sv
`timescale 1ns/100ps
`default_nettype none

module bus_bridge_tb;
  import bus_pkg::*;

  localparam int N_ITER = 30;
  localparam int N_CONC = 4;
  // store, load, fetch per iteration, two per pair, three timer reads
  localparam int TXN   = N_ITER * 3 + N_CONC * 2 + 3;
  localparam int LIMIT = TXN * 40;

  logic clk = 1'b0;
  logic arst_n_i;
  logic ifu_arvalid_i, lsu_arvalid_i, lsu_awvalid_i;
  logic [31:0] ifu_araddr_i, lsu_araddr_i, lsu_awaddr_i, lsu_wdata_i;
  logic [3:0] lsu_rstrb_i, lsu_wstrb_i;
  logic ifu_rvalid_o, lsu_rvalid_o, lsu_wready_o;
  logic [31:0] ifu_rdata_o, lsu_rdata_o;
  logic [3:0] m_axi_awid, m_axi_arid, m_axi_bid, m_axi_rid;
  logic [31:0] m_axi_awaddr, m_axi_araddr;
  logic [7:0] m_axi_awlen, m_axi_arlen;
  logic [2:0] m_axi_awsize, m_axi_arsize;
  logic [1:0] m_axi_awburst, m_axi_arburst, m_axi_bresp, m_axi_rresp;
  logic m_axi_awvalid, m_axi_wvalid, m_axi_wlast, m_axi_bready;
  logic m_axi_arvalid, m_axi_rready, m_axi_rlast;
  logic [63:0] m_axi_wdata;
  logic [7:0] m_axi_wstrb;
  // slave outputs start low
  logic m_axi_awready = 1'b0;
  logic m_axi_wready = 1'b0;
  logic m_axi_bvalid = 1'b0;
  logic m_axi_arready = 1'b0;
  logic m_axi_rvalid = 1'b0;
  logic [63:0] m_axi_rdata = 64'd0;

  logic [15:0] lfsr = 16'd7;
  logic [7:0] ref_mem [0:255];
  logic [63:0] mem [0:31];
  int errors = 0;
  int reqs = 0;
  int dones = 0;
  int cycles = 0;
  int ar_count = 0;
  logic [2:0] exp_size;
  logic [7:0] exp_wstrb;
  time ifu_t, lsu_t;

  // slave bookkeeping
  logic [31:0] rd_addr, wr_addr;
  logic [63:0] wr_data;
  logic [7:0] wr_strb;
  logic [1:0] ar_wait, r_wait, aw_wait, w_wait, b_wait;
  logic r_pend, b_pend, aw_got, w_got;

  assign m_axi_bid = '0;
  assign m_axi_rid = '0;
  assign m_axi_bresp = 2'b00;
  assign m_axi_rresp = 2'b00;
  assign m_axi_rlast = 1'b1;

  bus_bridge_top DUT (.*);

  always #5 clk = ~clk;

  // fibonacci lfsr, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] rnd(input int n);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // initial byte content, from the whole byte address
  function automatic logic [7:0] byte_fill(input logic [7:0] a);
    return a ^ 8'hC3 ^ {a[3:0], a[7:4]};
  endfunction

  function automatic logic [63:0] dword_fill(input logic [4:0] idx);
    logic [63:0] d;
    for (int b = 0; b < 8; b++)
      d[b*8 +: 8] = byte_fill({idx, 3'(b)});
    return d;
  endfunction

  // one byte is size 0, two bytes size 1, four bytes size 2
  function automatic logic [2:0] size_from_strb(input logic [3:0] strb);
    return ($countones(strb) == 1) ? 3'd0 : ($countones(strb) == 2) ? 3'd1 : 3'd2;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t %s: got %h expected %h", $time, msg, got, exp);
    end
  endtask

  // AXI slave memory, random 0..3 cycle delays
  always @(posedge clk)
  begin
    if (!arst_n_i)
    begin
      for (int a = 0; a < 32; a++)
        mem[a] <= dword_fill(5'(a));
      {ar_wait, r_wait, aw_wait, w_wait, b_wait} <= '0;
      {r_pend, b_pend, aw_got, w_got} <= '0;
      {m_axi_arready, m_axi_rvalid, m_axi_awready, m_axi_wready, m_axi_bvalid} <= '0;
    end
    else
    begin
      if (m_axi_arvalid && m_axi_arready)
      begin
        check(32'(m_axi_arsize), 32'(exp_size), "arsize");
        check(32'({m_axi_arid, m_axi_arlen, m_axi_arburst}), 32'({4'd0, 8'd0, 2'b01}),
              "ar id, len and burst");
        m_axi_arready <= 1'b0;
        rd_addr <= m_axi_araddr;
        r_pend <= 1'b1;
        r_wait <= 2'(rnd(2));
        ar_wait <= 2'(rnd(2));
        ar_count <= ar_count + 1;
      end
      else if (m_axi_arvalid)
      begin
        if (ar_wait == 2'd0)
          m_axi_arready <= 1'b1;
        else
          ar_wait <= ar_wait - 2'd1;
      end
      if (m_axi_rvalid && m_axi_rready)
        m_axi_rvalid <= 1'b0;
      else if (r_pend && !m_axi_rvalid)
      begin
        if (r_wait == 2'd0)
        begin
          m_axi_rvalid <= 1'b1;
          m_axi_rdata <= mem[rd_addr[7:3]];
          r_pend <= 1'b0;
        end
        else
          r_wait <= r_wait - 2'd1;
      end
      // write address, size by strobe rule
      if (m_axi_awvalid && m_axi_awready)
      begin
        check(32'(m_axi_awsize), 32'(exp_size), "awsize");
        check(32'({m_axi_awid, m_axi_awlen, m_axi_awburst}), 32'({4'd0, 8'd0, 2'b01}),
              "aw id, len and burst");
        m_axi_awready <= 1'b0;
        wr_addr <= m_axi_awaddr;
        aw_got <= 1'b1;
        aw_wait <= 2'(rnd(2));
      end
      else if (m_axi_awvalid)
      begin
        if (aw_wait == 2'd0)
          m_axi_awready <= 1'b1;
        else
          aw_wait <= aw_wait - 2'd1;
      end
      // write data, lane and last
      if (m_axi_wvalid && m_axi_wready)
      begin
        check(32'(m_axi_wstrb), 32'(exp_wstrb), "wstrb lane");
        check(32'(m_axi_wlast), 32'd1, "wlast");
        m_axi_wready <= 1'b0;
        wr_data <= m_axi_wdata;
        wr_strb <= m_axi_wstrb;
        w_got <= 1'b1;
        w_wait <= 2'(rnd(2));
      end
      else if (m_axi_wvalid)
      begin
        if (w_wait == 2'd0)
          m_axi_wready <= 1'b1;
        else
          w_wait <= w_wait - 2'd1;
      end
      if (aw_got && w_got)
      begin
        for (int b = 0; b < 8; b++)
          if (wr_strb[b])
            mem[wr_addr[7:3]][b*8 +: 8] <= wr_data[b*8 +: 8];
        aw_got <= 1'b0;
        w_got <= 1'b0;
        b_pend <= 1'b1;
        b_wait <= 2'(rnd(2));
      end
      if (m_axi_bvalid && m_axi_bready)
        m_axi_bvalid <= 1'b0;
      else if (b_pend && !m_axi_bvalid)
      begin
        if (b_wait == 2'd0)
        begin
          m_axi_bvalid <= 1'b1;
          b_pend <= 1'b0;
        end
        else
          b_wait <= b_wait - 2'd1;
      end
    end
  end

  // done pulses and run limit
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (arst_n_i)
      dones <= dones + int'(ifu_rvalid_o) + int'(lsu_rvalid_o) + int'(lsu_wready_o);
    if (cycles > LIMIT)
    begin
      $display("timeout: no end of test after %0d cycles", LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic do_store(input logic [7:0] a8, input logic [31:0] data,
                          input logic [3:0] strb);
    // expected beat from the strobe rule
    exp_size = size_from_strb(strb);
    exp_wstrb = {4'b0000, strb} << {a8[2], a8[1:0]};
    @(posedge clk);
    lsu_awvalid_i <= 1'b1;
    lsu_awaddr_i <= {24'h800000, a8};
    lsu_wdata_i <= data;
    lsu_wstrb_i <= strb;
    reqs++;
    do @(posedge clk); while (!lsu_wready_o);
    lsu_awvalid_i <= 1'b0;
    for (int i = 0; i < 4; i++)
      if (strb[i])
        ref_mem[a8 + 8'(i)] = data[i*8 +: 8];
  endtask

  task automatic do_load(input logic [31:0] addr, input logic [3:0] strb,
                         output logic [31:0] data, output int lat);
    exp_size = size_from_strb(strb);
    @(posedge clk);
    lsu_arvalid_i <= 1'b1;
    lsu_araddr_i <= addr;
    lsu_rstrb_i <= strb;
    reqs++;
    lat = 0;
    do
    begin
      @(posedge clk);
      lat++;
    end
    while (!lsu_rvalid_o);
    // done was raised one edge before it is seen here
    lat--;
    data = lsu_rdata_o;
    lsu_t = $time;
    lsu_arvalid_i <= 1'b0;
  endtask

  task automatic load_check(input logic [7:0] a8, input logic [3:0] strb);
    logic [7:0] w;
    logic [31:0] exp;
    logic [31:0] got;
    int lat;
    w = a8 & 8'hFC;
    // whole word, moved down by the byte offset
    exp = {ref_mem[w + 8'd3], ref_mem[w + 8'd2], ref_mem[w + 8'd1], ref_mem[w]};
    exp = exp >> {a8[1:0], 3'b000};
    do_load({24'h800000, a8}, strb, got, lat);
    check(got, exp, "load data");
    check(32'(lat >= 3), 32'd1, "AXI load latency below three");
  endtask

  task automatic fetch_check(input logic [7:0] a8);
    logic [31:0] exp;
    exp_size = size_from_strb(4'b1111);
    exp = {ref_mem[a8 + 8'd3], ref_mem[a8 + 8'd2], ref_mem[a8 + 8'd1], ref_mem[a8]};
    @(posedge clk);
    ifu_arvalid_i <= 1'b1;
    ifu_araddr_i <= {24'h800000, a8};
    reqs++;
    do @(posedge clk); while (!ifu_rvalid_o);
    ifu_t = $time;
    check(ifu_rdata_o, exp, "fetch data");
    ifu_arvalid_i <= 1'b0;
  endtask

  initial
  begin
    logic [7:0] a8;
    logic [3:0] strb;
    logic [31:0] t0, t1, thi;
    logic [1:0] sz;
    int lat0, lat1, lat2, ar_before;
    {ifu_arvalid_i, lsu_arvalid_i, lsu_awvalid_i} = '0;
    {ifu_araddr_i, lsu_araddr_i, lsu_awaddr_i, lsu_wdata_i} = '0;
    lsu_rstrb_i = '0;
    lsu_wstrb_i = '0;
    for (int a = 0; a < 256; a++)
      ref_mem[a] = byte_fill(8'(a));
    arst_n_i = 1'b0;
    repeat (8) @(posedge clk);
    arst_n_i <= 1'b1;
    repeat (2) @(posedge clk);
    // stores of 1, 2 or 4 bytes, read back, plus a fetch
    for (int it = 0; it < N_ITER; it++)
    begin
      sz = 2'(rnd(2));
      if (sz == 2'd3)
        sz = 2'd2;
      strb = (sz == 2'd0) ? 4'b0001 : (sz == 2'd1) ? 4'b0011 : 4'b1111;
      a8 = 8'(rnd(8)) & (8'hFF << sz);
      do_store(a8, rnd(32), strb);
      load_check(a8, strb);
      fetch_check(8'(rnd(8)) & 8'hFC);
    end
    // fetch and load raised together, load goes first
    for (int c = 0; c < N_CONC; c++)
    begin
      a8 = 8'(rnd(8)) & 8'hFC;
      fork
        load_check(a8, 4'b1111);
        fetch_check(a8 ^ 8'h40);
      join
      check(32'(lsu_t < ifu_t), 32'd1, "load done not before fetch done");
    end
    // timer window, local and two cycles
    ar_before = ar_count;
    do_load(RTC_ADDR, 4'b1111, t0, lat0);
    do_load(RTC_ADDR, 4'b1111, t1, lat1);
    do_load(RTC_ADDR_UP, 4'b1111, thi, lat2);
    check(32'(lat0), 32'd2, "timer latency");
    check(32'(lat1), 32'd2, "timer latency");
    check(32'(lat2), 32'd2, "timer latency");
    check(32'(t1 > t0), 32'd1, "mtime not increasing");
    check(thi, 32'd0, "mtime high word");
    check(32'(ar_count), 32'(ar_before), "timer read reached AXI");
    repeat (4) @(posedge clk);
    check(32'(dones), 32'(reqs), "done count against request count");
    $display("errors: %0d", errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
rtl/bus_pkg.sv
rtl/bus_req_arbiter.sv
rtl/bus_lane_steer.sv
rtl/bus_axi_master.sv
rtl/bus_clint_timer.sv
rtl/bus_bridge_top.sv
verification/bus_bridge_assertions.sv
verification/bus_bridge_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= bus_bridge_tb
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
